/* build.f */
design/gridPkg.sv
design/seqCtrlIf.sv
design/hostWritePort.sv
design/dualPortRam.sv
design/stateMemory.sv
design/addressGenerator.sv
design/microSequencer.sv
design/macDatapath.sv
design/resonantGridTop.sv
verification/resonantGridTop_assertions.sv
verification/resonantGridTb.sv

/* design/addressGenerator.sv */
`timescale 1ns/1ps
`default_nettype none

module addressGenerator (
	input logic clk_i,
	input logic harmonics_rst,
	input gridPkg::addrCmd_e cmd_i,
	input logic slot_i,
	input logic common_i,
	output gridPkg::memAddr_t addr_o
);

	gridPkg::memAddr_t base;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			base <= '0;
		end else begin
			case (cmd_i)
				gridPkg::NEXT: base <= base + gridPkg::HARMONIC_STRIDE;
				gridPkg::REWIND: base <= '0;
				default: base <= base;
			endcase
		end
	end

	// The command moves the base for the next word, this word still sees the old one
	assign addr_o = common_i ? gridPkg::COMMON_ADDR : base + gridPkg::memAddr_t'(slot_i);

endmodule

`default_nettype wire

/* design/dualPortRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dualPortRam (
	input logic clk_i,
	input logic we_i,
	input gridPkg::memAddr_t wrAddr_i,
	input gridPkg::word_t wrData_i,
	input gridPkg::memAddr_t rdAddr_i,
	output gridPkg::word_t rdData_o
);

	gridPkg::word_t mem [2**gridPkg::MEM_ADDR_WIDTH];

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
	end

	// Registered read returns the old word on a same-address write
	always_ff @(posedge clk_i) begin
		rdData_o <= mem[rdAddr_i];
	end

endmodule

`default_nettype wire

/* design/gridPkg.sv */
`default_nettype none

package gridPkg;

	localparam int MEM_ADDR_WIDTH = 9;
	localparam int WORD_WIDTH = 18;
	localparam int BUS_ADDR_WIDTH = 10; // Top bit picks coefficient memory over state memory
	localparam int HARM_CNT_WIDTH = 6;
	localparam int COEF_FRAC_BITS = 16;
	localparam int DATAPATH_DELAY = 1; // Matches the RAM read latency

	// Wide enough for the sum of two full products
	localparam int ACC_WIDTH = 2 * WORD_WIDTH + 1;

	typedef logic [MEM_ADDR_WIDTH-1:0] memAddr_t;
	typedef logic signed [WORD_WIDTH-1:0] word_t;

	localparam memAddr_t HARMONIC_STRIDE = 9'd2; // Slot 0 holds x1 or c, slot 1 holds x2 or s
	localparam memAddr_t COMMON_ADDR = 9'd256; // Harmonic count in coefficients, sum in states
	localparam logic [HARM_CNT_WIDTH-1:0] HARMONIC_MAX = 6'd32;

	typedef enum logic [2:0] {
		NOP,
		LOAD_A,
		SUB_A,
		LOAD_B,
		ADD_B
	} macOp_e;

	typedef enum logic [1:0] {
		NONE,
		X1,
		X2,
		SUM
	} wrSel_e;

	typedef enum logic [1:0] {
		HOLD,
		NEXT,
		REWIND
	} addrCmd_e;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_COUNT,
		LATCH_COUNT,
		ISSUE,
		DRAIN,
		WRITE_SUM
	} seqState_e;

endpackage

`default_nettype wire

/* design/hostWritePort.sv */
`timescale 1ns/1ps
`default_nettype none

module hostWritePort (
	input logic clk_i,
	input logic harmonics_rst,
	input logic wbCyc_i,
	input logic wbStb_i,
	input logic wbWe_i,
	input logic [gridPkg::BUS_ADDR_WIDTH-1:0] wbAdr_i,
	input gridPkg::word_t wbDat_i,
	input logic busy_i,
	output logic wbAck_o,
	output logic coefWe_o,
	output logic stateWe_o,
	output gridPkg::memAddr_t hostAddr_o,
	output gridPkg::word_t hostData_o
);

	logic coefSel;
	logic writeNow;

	// The !wbAck_o term splits back-to-back requests so each one completes once
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			wbAck_o <= 1'b0;
		end else begin
			wbAck_o <= wbCyc_i && wbStb_i && !wbAck_o && !busy_i;
		end
	end

	assign coefSel = wbAdr_i[gridPkg::BUS_ADDR_WIDTH-1];
	assign writeNow = wbAck_o && wbWe_i; // Host still holds address and data during the ack

	assign coefWe_o = writeNow && coefSel;
	assign stateWe_o = writeNow && !coefSel;

	assign hostAddr_o = wbAdr_i[gridPkg::MEM_ADDR_WIDTH-1:0];
	assign hostData_o = wbDat_i;

endmodule

`default_nettype wire

/* design/macDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module macDatapath (
	input logic clk_i,
	input logic harmonics_rst,
	input gridPkg::word_t stateRdData_i,
	input gridPkg::word_t coefRdData_i,
	seqCtrlIf.executor ctrl,
	output logic dpWe_o,
	output gridPkg::memAddr_t dpAddr_o,
	output gridPkg::word_t dpData_o,
	output logic sumDone_o
);

	gridPkg::macOp_e opPipe [gridPkg::DATAPATH_DELAY];
	gridPkg::wrSel_e wrSelPipe [gridPkg::DATAPATH_DELAY];
	logic slotPipe [gridPkg::DATAPATH_DELAY];
	gridPkg::addrCmd_e addrCmdPipe [gridPkg::DATAPATH_DELAY];
	logic sumClearPipe [gridPkg::DATAPATH_DELAY];

	gridPkg::macOp_e opNow;
	gridPkg::wrSel_e wrSelNow;
	gridPkg::word_t coefPrev;
	gridPkg::word_t coefOperand;
	gridPkg::word_t x1New;
	gridPkg::word_t x2New;
	gridPkg::word_t sumReg;
	logic signed [gridPkg::ACC_WIDTH-1:0] product;
	logic signed [gridPkg::ACC_WIDTH-1:0] accA;
	logic signed [gridPkg::ACC_WIDTH-1:0] accB;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < gridPkg::DATAPATH_DELAY; i++) begin
				opPipe[i] <= gridPkg::NOP;
				wrSelPipe[i] <= gridPkg::NONE;
				slotPipe[i] <= 1'b0;
				addrCmdPipe[i] <= gridPkg::HOLD;
				sumClearPipe[i] <= 1'b0;
			end
		end else begin
			opPipe[0] <= ctrl.op;
			wrSelPipe[0] <= ctrl.wrSel;
			slotPipe[0] <= ctrl.slot;
			addrCmdPipe[0] <= ctrl.addrCmd;
			sumClearPipe[0] <= ctrl.sumClear;
			for (int i = 1; i < gridPkg::DATAPATH_DELAY; i++) begin
				opPipe[i] <= opPipe[i-1];
				wrSelPipe[i] <= wrSelPipe[i-1];
				slotPipe[i] <= slotPipe[i-1];
				addrCmdPipe[i] <= addrCmdPipe[i-1];
				sumClearPipe[i] <= sumClearPipe[i-1];
			end
		end
	end

	assign opNow = opPipe[gridPkg::DATAPATH_DELAY-1];
	assign wrSelNow = wrSelPipe[gridPkg::DATAPATH_DELAY-1];

	always_ff @(posedge clk_i) begin
		coefPrev <= coefRdData_i;
	end

	assign coefOperand = (opNow == gridPkg::LOAD_B || opNow == gridPkg::ADD_B) ? coefPrev : coefRdData_i;
	assign product = stateRdData_i * coefOperand;

	always_ff @(posedge clk_i) begin
		case (opNow)
			gridPkg::LOAD_A: accA <= product;
			gridPkg::SUB_A: accA <= accA - product;
			gridPkg::LOAD_B: accB <= product;
			gridPkg::ADD_B: accB <= accB + product;
			default: ;
		endcase
		if (sumClearPipe[gridPkg::DATAPATH_DELAY-1]) begin
			sumReg <= '0;
		end else if (wrSelNow == gridPkg::X1) begin
			sumReg <= sumReg + x1New; // Wraps at 18 bits like the stored words
		end
	end

	// Taking the slice above the fraction bits is the arithmetic shift plus the wrap
	assign x1New = accA[gridPkg::COEF_FRAC_BITS +: gridPkg::WORD_WIDTH];
	assign x2New = accB[gridPkg::COEF_FRAC_BITS +: gridPkg::WORD_WIDTH];

	always_comb begin
		case (wrSelNow)
			gridPkg::X1: dpData_o = x1New;
			gridPkg::X2: dpData_o = x2New;
			gridPkg::SUM: dpData_o = sumReg;
			default: dpData_o = '0;
		endcase
	end

	assign dpWe_o = wrSelNow != gridPkg::NONE;
	assign sumDone_o = wrSelNow == gridPkg::SUM;

	addressGenerator writeAddrGen (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.cmd_i(addrCmdPipe[gridPkg::DATAPATH_DELAY-1]),
		.slot_i(slotPipe[gridPkg::DATAPATH_DELAY-1]),
		.common_i(sumDone_o),
		.addr_o(dpAddr_o)
	);

endmodule

`default_nettype wire

/* design/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input gridPkg::word_t coefRdData_i,
	input logic sumDone_i,
	output logic busy_o,
	output gridPkg::addrCmd_e rdCmd_o,
	output logic rdSlot_o,
	output logic rdCommon_o,
	seqCtrlIf.issuer ctrl
);

	gridPkg::seqState_e state;
	logic [1:0] phase;
	logic [gridPkg::HARM_CNT_WIDTH-1:0] harmIdx;
	logic [gridPkg::HARM_CNT_WIDTH-1:0] harmCount;
	logic [gridPkg::HARM_CNT_WIDTH-1:0] countSat;
	logic lastHarm;

	// Negative words read as huge unsigned values and saturate too
	assign countSat = ($unsigned(coefRdData_i) > gridPkg::HARMONIC_MAX) ?
		gridPkg::HARMONIC_MAX : coefRdData_i[gridPkg::HARM_CNT_WIDTH-1:0];

	assign lastHarm = (harmIdx + 1'b1) == harmCount;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state <= gridPkg::IDLE;
			busy_o <= 1'b0;
			phase <= '0;
			harmIdx <= '0;
			harmCount <= '0;
		end else begin
			case (state)
				gridPkg::IDLE: begin
					if (start_i && !busy_o) begin // Busy stays up one cycle past WRITE_SUM
						state <= gridPkg::FETCH_COUNT;
						busy_o <= 1'b1;
					end
				end
				gridPkg::FETCH_COUNT: begin
					state <= gridPkg::LATCH_COUNT;
				end
				gridPkg::LATCH_COUNT: begin
					harmCount <= countSat;
					harmIdx <= '0;
					phase <= '0;
					state <= (countSat == '0) ? gridPkg::WRITE_SUM : gridPkg::ISSUE;
				end
				gridPkg::ISSUE: begin
					phase <= phase + 1'b1;
					if (phase == 2'd3) begin
						harmIdx <= harmIdx + 1'b1;
						if (lastHarm) begin
							state <= gridPkg::DRAIN;
						end
					end
				end
				gridPkg::DRAIN: begin
					state <= gridPkg::WRITE_SUM;
				end
				default: begin
					state <= gridPkg::IDLE;
				end
			endcase
			if (sumDone_i) begin
				busy_o <= 1'b0;
			end
		end
	end

	// B terms pair the state word with the coefficient of the previous read,
	// so slots 0,1,0,1 give the operand pairs (x1,c) (x2,s) (x1,s) (x2,c)
	always_comb begin
		ctrl.op = gridPkg::NOP;
		ctrl.wrSel = gridPkg::NONE;
		ctrl.slot = 1'b0;
		ctrl.addrCmd = gridPkg::HOLD;
		ctrl.sumClear = 1'b0;
		rdCmd_o = gridPkg::HOLD;
		rdSlot_o = 1'b0;
		rdCommon_o = 1'b0;
		case (state)
			gridPkg::FETCH_COUNT: begin
				rdCommon_o = 1'b1;
				rdCmd_o = gridPkg::REWIND;
				ctrl.addrCmd = gridPkg::REWIND;
				ctrl.sumClear = 1'b1;
			end
			gridPkg::ISSUE: begin
				case (phase)
					2'd0: begin
						ctrl.op = gridPkg::LOAD_A;
						if (harmIdx != '0) begin // x2' of the previous harmonic
							ctrl.wrSel = gridPkg::X2;
							ctrl.slot = 1'b1;
							ctrl.addrCmd = gridPkg::NEXT;
						end
					end
					2'd1: begin
						ctrl.op = gridPkg::SUB_A;
						rdSlot_o = 1'b1;
					end
					2'd2: begin
						ctrl.op = gridPkg::LOAD_B;
						ctrl.wrSel = gridPkg::X1;
					end
					default: begin
						ctrl.op = gridPkg::ADD_B;
						rdSlot_o = 1'b1;
						rdCmd_o = gridPkg::NEXT;
					end
				endcase
			end
			gridPkg::DRAIN: begin
				ctrl.wrSel = gridPkg::X2;
				ctrl.slot = 1'b1;
				ctrl.addrCmd = gridPkg::NEXT;
			end
			gridPkg::WRITE_SUM: begin
				ctrl.wrSel = gridPkg::SUM;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/resonantGridTop.sv */
`timescale 1ns/1ps
`default_nettype none

module resonantGridTop (
	input logic clk_i,
	input logic harmonics_rst,
	input logic wbCyc_i,
	input logic wbStb_i,
	input logic wbWe_i,
	input logic [gridPkg::BUS_ADDR_WIDTH-1:0] wbAdr_i,
	input gridPkg::word_t wbDat_i,
	input logic start_i,
	output logic wbAck_o,
	output logic busy_o,
	output logic resultWe_o,
	output gridPkg::memAddr_t resultAddr_o,
	output gridPkg::word_t resultData_o
);

	logic coefWe;
	logic stateWe;
	gridPkg::memAddr_t hostAddr;
	gridPkg::word_t hostData;
	gridPkg::memAddr_t rdAddr;
	gridPkg::word_t coefRdData;
	gridPkg::word_t stateRdData;
	gridPkg::addrCmd_e rdCmd;
	logic rdSlot;
	logic rdCommon;
	logic sumDone;

	seqCtrlIf ctrlBus ();

	hostWritePort hostPort (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.wbCyc_i(wbCyc_i),
		.wbStb_i(wbStb_i),
		.wbWe_i(wbWe_i),
		.wbAdr_i(wbAdr_i),
		.wbDat_i(wbDat_i),
		.busy_i(busy_o),
		.wbAck_o(wbAck_o),
		.coefWe_o(coefWe),
		.stateWe_o(stateWe),
		.hostAddr_o(hostAddr),
		.hostData_o(hostData)
	);

	dualPortRam coefMem (
		.clk_i(clk_i),
		.we_i(coefWe),
		.wrAddr_i(hostAddr),
		.wrData_i(hostData),
		.rdAddr_i(rdAddr),
		.rdData_o(coefRdData)
	);

	stateMemory stateMem (
		.clk_i(clk_i),
		.hostWe_i(stateWe),
		.hostAddr_i(hostAddr),
		.hostData_i(hostData),
		.dpWe_i(resultWe_o), // Result port is the engine's own write port
		.dpAddr_i(resultAddr_o),
		.dpData_i(resultData_o),
		.rdAddr_i(rdAddr),
		.rdData_o(stateRdData)
	);

	addressGenerator readAddrGen (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.cmd_i(rdCmd),
		.slot_i(rdSlot),
		.common_i(rdCommon),
		.addr_o(rdAddr)
	);

	microSequencer sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.coefRdData_i(coefRdData),
		.sumDone_i(sumDone),
		.busy_o(busy_o),
		.rdCmd_o(rdCmd),
		.rdSlot_o(rdSlot),
		.rdCommon_o(rdCommon),
		.ctrl(ctrlBus.issuer)
	);

	macDatapath datapath (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.stateRdData_i(stateRdData),
		.coefRdData_i(coefRdData),
		.ctrl(ctrlBus.executor),
		.dpWe_o(resultWe_o),
		.dpAddr_o(resultAddr_o),
		.dpData_o(resultData_o),
		.sumDone_o(sumDone)
	);

endmodule

`default_nettype wire

/* design/seqCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

// One control word per cycle, an idle word is NOP with NONE
interface seqCtrlIf;

	gridPkg::macOp_e op;
	gridPkg::wrSel_e wrSel;
	logic slot; // Write slot
	gridPkg::addrCmd_e addrCmd; // Steers the write address generator
	logic sumClear;

	modport issuer (
		output op, wrSel, slot, addrCmd, sumClear
	);

	modport executor (
		input op, wrSel, slot, addrCmd, sumClear
	);

endinterface

`default_nettype wire

/* design/stateMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module stateMemory (
	input logic clk_i,
	input logic hostWe_i,
	input gridPkg::memAddr_t hostAddr_i,
	input gridPkg::word_t hostData_i,
	input logic dpWe_i,
	input gridPkg::memAddr_t dpAddr_i,
	input gridPkg::word_t dpData_i,
	input gridPkg::memAddr_t rdAddr_i,
	output gridPkg::word_t rdData_o
);

	logic we;
	gridPkg::memAddr_t wrAddr;
	gridPkg::word_t wrData;

	assign we = dpWe_i || hostWe_i;
	assign wrAddr = dpWe_i ? dpAddr_i : hostAddr_i; // Engine writes win over the host
	assign wrData = dpWe_i ? dpData_i : hostData_i;

	dualPortRam stateRam (
		.clk_i(clk_i),
		.we_i(we),
		.wrAddr_i(wrAddr),
		.wrData_i(wrData),
		.rdAddr_i(rdAddr_i),
		.rdData_o(rdData_o)
	);

endmodule

`default_nettype wire

/* verification/resonantGridTb.sv */
`timescale 1ns/1ps
`default_nettype none

module resonantGridTb;

	localparam int RUN_COUNT = 7; // Runs over all five tests
	localparam int WRITE_COUNT = 148; // Bus writes over all five tests
	localparam int CYCLE_LIMIT =
		RUN_COUNT * (4 * int'(gridPkg::HARMONIC_MAX) + 16) + 4 * WRITE_COUNT;

	logic clk;
	logic harmonics_rst;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [gridPkg::BUS_ADDR_WIDTH-1:0] wbAdr;
	gridPkg::word_t wbDat;
	logic start;
	logic wbAck;
	logic busy;
	logic resultWe;
	gridPkg::memAddr_t resultAddr;
	gridPkg::word_t resultData;

	int seed = 32'h2e222299;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int assertFailures;
	logic runDone;
	gridPkg::word_t stateModel [2**gridPkg::MEM_ADDR_WIDTH];
	gridPkg::word_t coefModel [2**gridPkg::MEM_ADDR_WIDTH];
	logic signed [31:0] expAddr [$];
	logic signed [31:0] expData [$];
	logic signed [31:0] gotAddr [$];
	logic signed [31:0] gotData [$];

	resonantGridTop resonantGridTop_i (
		.clk_i(clk),
		.harmonics_rst(harmonics_rst),
		.wbCyc_i(wbCyc),
		.wbStb_i(wbStb),
		.wbWe_i(wbWe),
		.wbAdr_i(wbAdr),
		.wbDat_i(wbDat),
		.start_i(start),
		.wbAck_o(wbAck),
		.busy_o(busy),
		.resultWe_o(resultWe),
		.resultAddr_o(resultAddr),
		.resultData_o(resultData)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	task automatic checkValue(input logic signed [31:0] got, input logic signed [31:0] expected,
		input string what);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// Holds the request over the rising edge that takes the write, as Wishbone classic asks
	task automatic wbWrite(input logic [gridPkg::BUS_ADDR_WIDTH-1:0] adr, input gridPkg::word_t dat);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDat = dat;
		@(negedge clk);
		while (!wbAck) begin
			@(negedge clk);
		end
		@(negedge clk);
		checkValue(wbAck, 1'b0, "ack held for a second cycle");
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic writeState(input gridPkg::memAddr_t addr, input gridPkg::word_t data);
		stateModel[addr] = data;
		wbWrite({1'b0, addr}, data);
	endtask

	task automatic writeCoef(input gridPkg::memAddr_t addr, input gridPkg::word_t data);
		coefModel[addr] = data;
		wbWrite({1'b1, addr}, data);
	endtask

	function automatic gridPkg::word_t wrapShift(input longint acc);
		longint shifted;
		shifted = acc >>> 16;
		return shifted[17:0];
	endfunction

	// Rotates the model bank and queues the strobes a run should produce
	task automatic buildExpected(input int count);
		longint c, s, x1, x2;
		gridPkg::word_t x1New;
		gridPkg::word_t x2New;
		gridPkg::word_t sumWord;
		expAddr.delete();
		expData.delete();
		sumWord = '0;
		for (int h = 0; h < count; h++) begin
			x1 = stateModel[2*h];
			x2 = stateModel[2*h+1];
			c = coefModel[2*h];
			s = coefModel[2*h+1];
			x1New = wrapShift(c * x1 - s * x2);
			x2New = wrapShift(s * x1 + c * x2);
			stateModel[2*h] = x1New;
			stateModel[2*h+1] = x2New;
			sumWord = sumWord + x1New; // Wraps at 18 bits
			expAddr.push_back(2*h);
			expData.push_back(x1New);
			expAddr.push_back(2*h+1);
			expData.push_back(x2New);
		end
		stateModel[gridPkg::COMMON_ADDR] = sumWord;
		expAddr.push_back(gridPkg::COMMON_ADDR);
		expData.push_back(sumWord);
	endtask

	task automatic runEngine();
		gotAddr.delete();
		gotData.delete();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		checkValue(busy, 1'b1, "busy after start");
		while (busy) begin
			if (resultWe) begin
				gotAddr.push_back(resultAddr);
				gotData.push_back(resultData);
			end
			@(negedge clk);
		end
	endtask

	task automatic compareResults(input string name);
		int n;
		checkValue(gotAddr.size(), expAddr.size(), {name, ": number of result strobes"});
		n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
		for (int i = 0; i < n; i++) begin
			checkValue(gotAddr[i], expAddr[i], $sformatf("%s: address of strobe %0d", name, i));
			checkValue(gotData[i], expData[i], $sformatf("%s: data of strobe %0d", name, i));
		end
	endtask

	task automatic runAndCheck(input int count, input string name);
		buildExpected(count);
		runEngine();
		compareResults(name);
	endtask

	task automatic identityTest();
		writeState(9'd0, 18'sd12345);
		writeState(9'd1, -18'sd2222);
		writeCoef(9'd0, 18'sd65536); // 1.0 in 16 fraction bits
		writeCoef(9'd1, 18'sd0);
		writeCoef(gridPkg::COMMON_ADDR, 18'sd1);
		runAndCheck(1, "identity");
		checkValue(gotData[0], 12345, "identity: x1 kept");
		checkValue(gotData[1], -2222, "identity: x2 kept");
		checkValue(gotData[2], 12345, "identity: sum equals x1");
	endtask

	task automatic quarterTest();
		writeState(9'd0, 18'sd1000);
		writeState(9'd1, -18'sd3000);
		writeState(9'd2, 18'sd50000);
		writeState(9'd3, 18'sd77);
		for (int h = 0; h < 2; h++) begin
			writeCoef(gridPkg::memAddr_t'(2*h), 18'sd0);
			writeCoef(gridPkg::memAddr_t'(2*h+1), 18'sd65536);
		end
		writeCoef(gridPkg::COMMON_ADDR, 18'sd2);
		runAndCheck(2, "quarter turn");
		checkValue(gotData[0], 3000, "quarter turn: x1 of harmonic 0");
		checkValue(gotData[3], 50000, "quarter turn: x2 of harmonic 1");
	endtask

	task automatic randomTest();
		int rnd;
		for (int a = 0; a < 64; a++) begin
			rnd = $random(seed);
			writeState(gridPkg::memAddr_t'(a), rnd[17:0]);
			rnd = $random(seed);
			writeCoef(gridPkg::memAddr_t'(a), rnd[17:0]);
		end
		writeCoef(gridPkg::COMMON_ADDR, 18'sd32);
		runAndCheck(32, "random bank");
		runAndCheck(32, "random bank second run"); // Starts from the written-back states
	endtask

	task automatic zeroTest();
		writeCoef(gridPkg::COMMON_ADDR, 18'sd0);
		runAndCheck(0, "zero count");
	endtask

	task automatic backPressureTest();
		writeCoef(9'd0, 18'sd65536);
		writeCoef(9'd1, 18'sd0);
		writeCoef(gridPkg::COMMON_ADDR, 18'sd1);
		buildExpected(1);
		runDone = 1'b0;
		fork
			begin
				runEngine();
				runDone = 1'b1;
			end
			begin
				@(negedge clk);
				writeCoef(9'd0, 18'sd32768);
				checkValue(runDone, 1'b1, "back-pressure: write acked before the run ended");
			end
		join
		compareResults("run with stalled write");
		runAndCheck(1, "run after stalled write");
	endtask

	initial begin
		harmonics_rst = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDat = '0;
		start = 1'b0;
		runDone = 1'b0;
		repeat (3) @(negedge clk);
		harmonics_rst = 1'b0;
		checkValue(wbAck, 1'b0, "wbAck_o after reset");
		checkValue(busy, 1'b0, "busy_o after reset");
		checkValue(resultWe, 1'b0, "resultWe_o after reset");
		identityTest();
		quarterTest();
		randomTest();
		zeroTest();
		backPressureTest();
		assertFailures = resonantGridTop_i.protocolChecks.failCount;
		$display("Errors: %0d in %0d checks, %0d assertion failures",
			errorCount, checkCount, assertFailures);
		if (errorCount == 0 && assertFailures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/resonantGridTop_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module resonantGridTopAssertions (
	input logic clk_i,
	input logic harmonics_rst,
	input logic wbCyc_i,
	input logic wbStb_i,
	input logic wbAck_i,
	input logic busy_i,
	input logic resultWe_i
);

	int failCount = 0; // Failed assertions so far

	ackNeedsRequest: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		wbAck_i |-> wbCyc_i && wbStb_i)
	else begin
		failCount++;
		$error("wbAck_o raised without wbCyc_i and wbStb_i");
	end

	ackSingleCycle: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		wbAck_i |=> !wbAck_i)
	else begin
		failCount++;
		$error("wbAck_o high for two cycles running");
	end

	noAckWhileBusy: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		wbAck_i |-> !busy_i)
	else begin
		failCount++;
		$error("wbAck_o given while the engine is busy");
	end

	resultOnlyWhileBusy: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		resultWe_i |-> busy_i)
	else begin
		failCount++;
		$error("resultWe_o strobe outside a run");
	end

endmodule

bind resonantGridTop resonantGridTopAssertions protocolChecks (
	.clk_i(clk_i),
	.harmonics_rst(harmonics_rst),
	.wbCyc_i(wbCyc_i),
	.wbStb_i(wbStb_i),
	.wbAck_i(wbAck_o),
	.busy_i(busy_o),
	.resultWe_i(resultWe_o)
);

`default_nettype wire
